/* hw/arcade_pkg.sv */
// Shared types and constants for the arcade control glue
// Key, joystick, player and host command structs
// Opcode and FSM state enums, timing and scan code constants

`default_nettype none

package arcade_pkg;

	// ============================================================
	// Control words
	// ============================================================

	typedef struct packed {
		logic fire;
		logic start1;
		logic start2;
		logic coin;
		logic left;
		logic right;
		logic down;
		logic up;
	} key_state_t;

	// Bit order matches the core's CSJUDRL input
	typedef struct packed {
		logic coin;
		logic start;
		logic fire;
		logic up;
		logic down;
		logic right;
		logic left;
	} player_ctrl_t;

	typedef struct packed {
		logic [2:0] spare;
		logic       fire;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_t;

	// ============================================================
	// Host command port
	// ============================================================

	typedef enum logic [1:0] {
		CMD_NOP         = 2'd0,
		CMD_SET_STATUS  = 2'd1,
		CMD_PULSE_RESET = 2'd2,
		CMD_SET_BUTTONS = 2'd3
	} cmd_op_e;

	typedef struct packed {
		cmd_op_e     op;
		logic [15:0] data;
	} host_cmd_t;

	typedef struct packed {
		logic       upright;
		logic [1:0] scanline_mode;
		logic       button_reset;
	} settings_t;

	typedef enum logic [1:0] {
		PS2_IDLE,
		PS2_DATA,
		PS2_PARITY,
		PS2_STOP
	} ps2_state_e;

	typedef enum logic [1:0] {
		CFG_IDLE,
		CFG_ACK,
		CFG_WAIT_LOW
	} cfg_state_e;

	localparam int RESET_PULSE_CYCLES = 16;
	localparam int RESET_CNT_W        = $clog2(RESET_PULSE_CYCLES + 1);
	localparam int PS2_FILTER_DEPTH   = 4;
	localparam int MIX_WIDTH          = 11;

	// Set 2 scan codes; the arrows follow an E0 prefix
	localparam logic [7:0] SC_BREAK = 8'hF0;
	localparam logic [7:0] SC_EXT   = 8'hE0;
	localparam logic [7:0] SC_SPACE = 8'h29;
	localparam logic [7:0] SC_1     = 8'h16;
	localparam logic [7:0] SC_2     = 8'h1E;
	localparam logic [7:0] SC_5     = 8'h2E;
	localparam logic [7:0] SC_UP    = 8'h75;
	localparam logic [7:0] SC_DOWN  = 8'h72;
	localparam logic [7:0] SC_LEFT  = 8'h6B;
	localparam logic [7:0] SC_RIGHT = 8'h74;

endpackage

`default_nettype wire

/* hw/ps2_keyboard_decoder.sv */
// PS/2 keyboard receiver
// Clock synchronizer and glitch filter, frame FSM with odd parity check,
// break and extended prefix handling, held-key register

`timescale 1ns/100ps
`default_nettype none

module ps2_keyboard_decoder
	import arcade_pkg::*;
(
	input  wire        clk_sys,
	input  wire        reset,
	input  wire        ps2_clk,
	input  wire        ps2_data,
	output key_state_t keys
);

	logic [1:0]                  clk_sync;
	logic [1:0]                  data_sync;
	logic [PS2_FILTER_DEPTH-1:0] clk_hist;
	logic                        clk_filt;
	logic                        clk_fall;
	logic                        data_bit;

	ps2_state_e state;
	logic [2:0] bit_cnt;
	logic [7:0] shift;
	logic       parity_ok;
	logic       release_flag;
	logic       ext_flag;

	// ============================================================
	// Line sampling
	// ============================================================

	// The filtered clock only moves once every sample in the window agrees
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_hist  <= '1;
			clk_filt  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_hist  <= {clk_hist[PS2_FILTER_DEPTH-2:0], clk_sync[1]};
			if (&clk_hist)
				clk_filt <= 1'b1;
			else if (~|clk_hist)
				clk_filt <= 1'b0;
		end
	end

	assign clk_fall = clk_filt & ~|clk_hist;
	assign data_bit = data_sync[1];

	// ============================================================
	// Frame FSM and key tracking
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state        <= PS2_IDLE;
			bit_cnt      <= '0;
			shift        <= '0;
			parity_ok    <= 1'b0;
			release_flag <= 1'b0;
			ext_flag     <= 1'b0;
			keys         <= '0;
		end else if (clk_fall) begin
			case (state)
				PS2_IDLE: begin
					// Start bit is a low data line
					if (!data_bit) begin
						state   <= PS2_DATA;
						bit_cnt <= '0;
					end
				end
				PS2_DATA: begin
					shift   <= {data_bit, shift[7:1]};
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7)
						state <= PS2_PARITY;
				end
				PS2_PARITY: begin
					// Odd parity over the data byte and the parity bit
					parity_ok <= ^{shift, data_bit};
					state     <= PS2_STOP;
				end
				PS2_STOP: begin
					state <= PS2_IDLE;
					if (data_bit && parity_ok) begin
						if (shift == SC_BREAK) begin
							release_flag <= 1'b1;
						end else if (shift == SC_EXT) begin
							ext_flag <= 1'b1;
						end else begin
							release_flag <= 1'b0;
							ext_flag     <= 1'b0;
							case (shift)
								SC_SPACE: keys.fire   <= ~release_flag;
								SC_1:     keys.start1 <= ~release_flag;
								SC_2:     keys.start2 <= ~release_flag;
								SC_5:     keys.coin   <= ~release_flag;
								SC_UP:    if (ext_flag) keys.up    <= ~release_flag;
								SC_DOWN:  if (ext_flag) keys.down  <= ~release_flag;
								SC_LEFT:  if (ext_flag) keys.left  <= ~release_flag;
								SC_RIGHT: if (ext_flag) keys.right <= ~release_flag;
								default:  ;
							endcase
						end
					end
				end
				default: state <= PS2_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/host_config_port.sv */
// Host configuration slave
// Four-phase req/ack handshake, status settings register and
// reset pulse timer

`timescale 1ns/100ps
`default_nettype none

module host_config_port
	import arcade_pkg::*;
(
	input  wire        clk_sys,
	input  wire        reset,
	input  wire        cfg_req,
	input  host_cmd_t  cfg_cmd,
	output logic       cfg_ack,
	output settings_t  settings,
	output logic       reset_pulse
);

	cfg_state_e             state;
	logic [RESET_CNT_W-1:0] pulse_cnt;

	// Ack stays up from the accepting edge until one cycle after req drops
	assign cfg_ack     = (state != CFG_IDLE);
	assign reset_pulse = (pulse_cnt != '0);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state                  <= CFG_IDLE;
			pulse_cnt              <= '0;
			settings.upright       <= 1'b1;
			settings.scanline_mode <= 2'b00;
			settings.button_reset  <= 1'b0;
		end else begin
			if (pulse_cnt != '0)
				pulse_cnt <= pulse_cnt - 1'b1;

			case (state)
				CFG_IDLE: begin
					if (cfg_req) begin
						state <= CFG_ACK;
						// The command takes effect on the same edge as ack
						case (cfg_cmd.op)
							CMD_SET_STATUS: begin
								settings.upright       <= cfg_cmd.data[2];
								settings.scanline_mode <= cfg_cmd.data[4:3];
							end
							CMD_SET_BUTTONS: settings.button_reset <= cfg_cmd.data[1];
							CMD_PULSE_RESET: pulse_cnt <= RESET_CNT_W'(RESET_PULSE_CYCLES);
							default: ;
						endcase
					end
				end
				CFG_ACK: begin
					if (!cfg_req)
						state <= CFG_WAIT_LOW;
				end
				CFG_WAIT_LOW: state <= CFG_IDLE;
				default:      state <= CFG_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/control_mapper.sv */
// Player control mapper
// Merges keyboard and both joysticks, applies the cabinet orientation,
// and registers the player words and the core reset

`timescale 1ns/100ps
`default_nettype none

module control_mapper
	import arcade_pkg::*;
(
	input  wire          clk_sys,
	input  wire          reset,
	input  key_state_t   keys,
	input  joy_t         joystick_0,
	input  joy_t         joystick_1,
	input  settings_t    settings,
	input  wire          reset_pulse,
	output player_ctrl_t p1,
	output player_ctrl_t p2,
	output logic         core_reset
);

	logic         m_up;
	logic         m_down;
	logic         m_left;
	logic         m_right;
	logic         m_fire;
	player_ctrl_t p1_next;
	player_ctrl_t p2_next;

	always_comb begin
		m_up    = keys.up    | joystick_0.up    | joystick_1.up;
		m_down  = keys.down  | joystick_0.down  | joystick_1.down;
		m_left  = keys.left  | joystick_0.left  | joystick_1.left;
		m_right = keys.right | joystick_0.right | joystick_1.right;
		m_fire  = keys.fire  | joystick_0.fire  | joystick_1.fire;

		p1_next       = '0;
		p1_next.coin  = keys.coin;
		p1_next.start = keys.start1;
		p1_next.fire  = m_fire;

		p2_next       = '0;
		p2_next.start = keys.start2;
		p2_next.fire  = m_fire;

		// P1 only uses left/right and P2 only up/down on this core
		if (settings.upright) begin
			p1_next.left  = m_left;
			p1_next.right = m_right;
			p2_next.up    = m_down;
			p2_next.down  = m_up;
		end else begin
			// Rotated cabinet turns the stick a quarter turn
			p1_next.left  = m_down;
			p1_next.right = m_up;
			p2_next.up    = m_right;
			p2_next.down  = m_left;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			p1         <= '0;
			p2         <= '0;
			core_reset <= 1'b1;
		end else begin
			p1         <= p1_next;
			p2         <= p2_next;
			core_reset <= reset_pulse | settings.button_reset;
		end
	end

endmodule

`default_nettype wire

/* hw/audio_dac.sv */
// Audio mixer and first-order sigma-delta modulator
// Output bit density tracks the 11-bit mix of both channels

`timescale 1ns/100ps
`default_nettype none

module audio_dac
	import arcade_pkg::*;
(
	input  wire       clk_sys,
	input  wire       reset,
	input  wire [7:0] audio_a,
	input  wire [7:0] audio_b,
	output logic      audio_out
);

	logic [MIX_WIDTH-1:0] mix;
	logic [MIX_WIDTH-1:0] acc;
	logic [MIX_WIDTH:0]   sum;

	// Channel B is weighted four times louder than channel A
	always_ff @(posedge clk_sys) begin
		if (reset)
			mix <= '0;
		else
			mix <= {1'b0, audio_b, 2'b00} + {3'b000, audio_a};
	end

	assign sum = {1'b0, acc} + {1'b0, mix};

	// The carry out of the accumulator is the output bitstream
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc       <= '0;
			audio_out <= 1'b0;
		end else begin
			acc       <= sum[MIX_WIDTH-1:0];
			audio_out <= sum[MIX_WIDTH];
		end
	end

endmodule

`default_nettype wire

/* hw/arcade_control_top.sv */
// Top level of the arcade control and audio glue
// Keyboard decoder and host port feed the control mapper;
// the sigma-delta DAC runs beside them

`timescale 1ns/100ps
`default_nettype none

module arcade_control_top
	import arcade_pkg::*;
(
	input  wire          clk_sys,
	input  wire          reset,
	input  wire          ps2_clk,
	input  wire          ps2_data,
	input  wire          cfg_req,
	input  host_cmd_t    cfg_cmd,
	output logic         cfg_ack,
	input  joy_t         joystick_0,
	input  joy_t         joystick_1,
	input  wire [7:0]    audio_a,
	input  wire [7:0]    audio_b,
	output player_ctrl_t p1,
	output player_ctrl_t p2,
	output logic         core_reset,
	output logic [1:0]   scanline_mode,
	output logic         audio_out
);

	key_state_t keys;
	settings_t  settings;
	logic       reset_pulse;

	ps2_keyboard_decoder u_keyboard (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.keys     (keys)
	);

	host_config_port u_config (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cfg_req     (cfg_req),
		.cfg_cmd     (cfg_cmd),
		.cfg_ack     (cfg_ack),
		.settings    (settings),
		.reset_pulse (reset_pulse)
	);

	control_mapper u_mapper (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.keys        (keys),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.settings    (settings),
		.reset_pulse (reset_pulse),
		.p1          (p1),
		.p2          (p2),
		.core_reset  (core_reset)
	);

	audio_dac u_dac (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.audio_a   (audio_a),
		.audio_b   (audio_b),
		.audio_out (audio_out)
	);

	// Scanline mode goes out to the video path unchanged
	assign scanline_mode = settings.scanline_mode;

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// Testbench clock and reset source
// 100 ns system clock, reset held high for the first five rising edges

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

/* testbench/tb_checker.sv */
// Output checker for the arcade control testbench
// Settling compare of the player words, core reset and scanline mode,
// reset pulse and sigma-delta ones counters, per-test and total reports

`timescale 1ns/100ps
`default_nettype none

module tb_checker
	import arcade_pkg::*;
(
	input wire          clk_sys,
	input player_ctrl_t p1,
	input player_ctrl_t p2,
	input wire          core_reset,
	input wire [1:0]    scanline_mode,
	input wire          audio_out
);

	localparam int SETTLE_LIMIT = 100;
	localparam int PULSE_LIMIT  = 64;

	int error_count = 0;
	int test_count  = 0;
	int test_errors = 0;

	task automatic start_test();
		test_errors = 0;
	endtask

	task automatic note_failure(input string msg);
		$display("At %0t: %s", $time, msg);
		test_errors++;
		error_count++;
	endtask

	task automatic compare_value(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		if (act !== exp) begin
			$display("ERR time=%0t signal=%s expected=%0h actual=%0h", $time, name, exp, act);
			test_errors++;
			error_count++;
		end
	endtask

	function automatic logic outputs_match(input player_ctrl_t e1, input player_ctrl_t e2,
		input logic e_reset, input logic [1:0] e_scan);
		return (p1 === e1) && (p2 === e2) && (core_reset === e_reset) &&
			(scanline_mode === e_scan);
	endfunction

	// ============================================================
	// Output compare
	// ============================================================

	// Registered outputs and PS/2 latency both settle within the window
	task automatic check_outputs(input player_ctrl_t e1, input player_ctrl_t e2,
		input logic e_reset, input logic [1:0] e_scan);
		int waited;
		waited = 0;
		@(negedge clk_sys);
		while (!outputs_match(e1, e2, e_reset, e_scan) && waited < SETTLE_LIMIT) begin
			@(negedge clk_sys);
			waited++;
		end
		compare_value("p1", 16'(e1), 16'(p1));
		compare_value("p2", 16'(e2), 16'(p2));
		compare_value("core_reset", 16'(e_reset), 16'(core_reset));
		compare_value("scanline_mode", 16'(e_scan), 16'(scanline_mode));
	endtask

	task automatic count_reset_pulse(input int expected);
		int waited;
		int high_cycles;
		waited = 0;
		high_cycles = 0;
		@(negedge clk_sys);
		while (!core_reset && waited < PULSE_LIMIT) begin
			@(negedge clk_sys);
			waited++;
		end
		if (!core_reset) begin
			note_failure("core_reset never went high after the reset pulse command");
		end else begin
			while (core_reset && high_cycles < PULSE_LIMIT) begin
				high_cycles++;
				@(negedge clk_sys);
			end
			compare_value("core_reset high cycles", 16'(expected), 16'(high_cycles));
		end
	endtask

	// ============================================================
	// Sigma-delta density
	// ============================================================

	task automatic count_audio(input int expected);
		int ones;
		int diff;
		ones = 0;
		repeat (4) @(negedge clk_sys);
		for (int i = 0; i < 2048; i++) begin
			@(negedge clk_sys);
			ones += audio_out;
		end
		diff = ones - expected;
		if (diff > 1 || diff < -1)
			compare_value("audio_out ones", 16'(expected), 16'(ones));
	endtask

	task automatic end_test(input int idx, input string label);
		test_count++;
		if (test_errors == 0)
			$display("test %0d %s: ok", idx, label);
		else
			$display("test %0d %s: %0d error(s)", idx, label, test_errors);
	endtask

	task automatic report();
		$display("%0d tests run, %0d errors", test_count, error_count);
	endtask

endmodule

`default_nettype wire

/* testbench/tb_arcade_control.sv */
// Testbench top for the arcade control and audio glue
// Stimulus table applied in a loop, PS/2 frame and host handshake drivers,
// reference mapping for random joystick rows, DUT and checker instances

`timescale 1ns/100ps
`default_nettype none

module tb_arcade_control
	import arcade_pkg::*;
();

	localparam int PS2_HALF  = 10;
	localparam int ACK_LIMIT = 16;

	typedef enum logic [3:0] {
		ACT_CHECK, ACT_CFG, ACT_PULSE, ACT_PRESS, ACT_RELEASE, ACT_BAD_PARITY,
		ACT_JOY, ACT_JOY_RAND, ACT_AUDIO, ACT_AUDIO_RAND
	} act_e;

	// Key rows carry {extended, code}; random joystick rows carry {upright, held keys}
	typedef struct packed {
		act_e         action;
		logic [17:0]  operand;
		player_ctrl_t exp_p1;
		player_ctrl_t exp_p2;
		logic         exp_reset;
		logic [1:0]   exp_scan;
		logic [10:0]  exp_ones;
	} row_t;

	logic         clk_sys;
	logic         reset;
	logic         ps2_clk;
	logic         ps2_data;
	logic         cfg_req;
	host_cmd_t    cfg_cmd;
	logic         cfg_ack;
	joy_t         joystick_0;
	joy_t         joystick_1;
	logic [7:0]   audio_a;
	logic [7:0]   audio_b;
	player_ctrl_t p1;
	player_ctrl_t p2;
	logic         core_reset;
	logic [1:0]   scanline_mode;
	logic         audio_out;

	row_t   rows[$];
	logic   timed_out;
	integer seed;

	tb_clock_gen clk_gen (.clk_sys(clk_sys), .reset(reset));

	arcade_control_top uut (
		.clk_sys(clk_sys), .reset(reset), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
		.cfg_req(cfg_req), .cfg_cmd(cfg_cmd), .cfg_ack(cfg_ack),
		.joystick_0(joystick_0), .joystick_1(joystick_1),
		.audio_a(audio_a), .audio_b(audio_b), .p1(p1), .p2(p2),
		.core_reset(core_reset), .scanline_mode(scanline_mode), .audio_out(audio_out)
	);

	tb_checker chk (
		.clk_sys(clk_sys), .p1(p1), .p2(p2), .core_reset(core_reset),
		.scanline_mode(scanline_mode), .audio_out(audio_out)
	);

	task automatic add_row(input act_e action, input logic [17:0] operand,
		input logic [6:0] e1, input logic [6:0] e2, input logic e_reset,
		input logic [1:0] e_scan, input logic [10:0] ones);
		row_t row;
		row = {action, operand, e1, e2, e_reset, e_scan, ones};
		rows.push_back(row);
	endtask

	// Expected player words from the cabinet orientation rule
	function automatic void map_players(input key_state_t k, input joy_t j0, input joy_t j1,
		input logic upright, output player_ctrl_t e1, output player_ctrl_t e2);
		logic up;
		logic down;
		logic left;
		logic right;
		up    = k.up | j0.up | j1.up;
		down  = k.down | j0.down | j1.down;
		left  = k.left | j0.left | j1.left;
		right = k.right | j0.right | j1.right;
		e1 = '0;
		e2 = '0;
		e1.coin  = k.coin;
		e1.start = k.start1;
		e1.fire  = k.fire | j0.fire | j1.fire;
		e2.start = k.start2;
		e2.fire  = e1.fire;
		e1.left  = upright ? left : down;
		e1.right = upright ? right : up;
		e2.up    = upright ? down : right;
		e2.down  = upright ? up : left;
	endfunction

	// ============================================================
	// Drivers
	// ============================================================

	// Start bit, eight data bits LSB first, odd parity, stop bit
	task automatic send_ps2_byte(input logic [7:0] code, input logic bad_parity);
		logic [10:0] frame;
		frame = {1'b1, ~^code ^ bad_parity, code, 1'b0};
		@(posedge clk_sys);
		for (int i = 0; i < 11; i++) begin
			ps2_data <= frame[i];
			repeat (PS2_HALF) @(posedge clk_sys);
			ps2_clk <= 1'b0;
			repeat (PS2_HALF) @(posedge clk_sys);
			ps2_clk <= 1'b1;
		end
		repeat (2 * PS2_HALF) @(posedge clk_sys);
	endtask

	task automatic send_key(input logic [8:0] key, input logic release_key,
		input logic bad_parity);
		if (key[8])
			send_ps2_byte(SC_EXT, 1'b0);
		if (release_key)
			send_ps2_byte(SC_BREAK, 1'b0);
		send_ps2_byte(key[7:0], bad_parity);
	endtask

	task automatic wait_ack(input logic level, output int waited);
		waited = 0;
		@(negedge clk_sys);
		while (cfg_ack !== level && waited < ACK_LIMIT) begin
			@(negedge clk_sys);
			waited++;
		end
	endtask

	task automatic send_cfg(input logic [17:0] operand);
		int waited;
		@(posedge clk_sys);
		cfg_cmd <= operand;
		cfg_req <= 1'b1;
		wait_ack(1'b1, waited);
		if (cfg_ack !== 1'b1) begin
			$display("Timeout: cfg_ack did not rise within %0d cycles", ACK_LIMIT);
			timed_out = 1'b1;
		end else if (waited != 1) begin
			chk.note_failure($sformatf("cfg_ack rose %0d cycles after req instead of 1", waited));
		end
		@(posedge clk_sys);
		cfg_req <= 1'b0;
		if (!timed_out) begin
			wait_ack(1'b0, waited);
			if (cfg_ack !== 1'b0) begin
				$display("Timeout: cfg_ack did not fall within %0d cycles", ACK_LIMIT);
				timed_out = 1'b1;
			end else if (waited != 2) begin
				chk.note_failure($sformatf("cfg_ack fell %0d cycles after req low, not 2", waited));
			end
		end
	endtask

	// ============================================================
	// Stimulus table
	// ============================================================

	task automatic build_table();
		add_row(ACT_CHECK, '0, 7'b0000000, 7'b0000000, 1'b0, 2'd0, '0);
		add_row(ACT_CFG, {CMD_SET_STATUS, 16'h0014}, 7'b0000000, 7'b0000000, 1'b0, 2'd2, '0);
		add_row(ACT_PRESS, {1'b0, SC_5}, 7'b1000000, 7'b0000000, 1'b0, 2'd2, '0);
		add_row(ACT_PRESS, {1'b0, SC_1}, 7'b1100000, 7'b0000000, 1'b0, 2'd2, '0);
		add_row(ACT_RELEASE, {1'b0, SC_5}, 7'b0100000, 7'b0000000, 1'b0, 2'd2, '0);
		add_row(ACT_RELEASE, {1'b0, SC_1}, 7'b0000000, 7'b0000000, 1'b0, 2'd2, '0);
		add_row(ACT_PRESS, {1'b0, SC_2}, 7'b0000000, 7'b0100000, 1'b0, 2'd2, '0);
		add_row(ACT_RELEASE, {1'b0, SC_2}, 7'b0000000, 7'b0000000, 1'b0, 2'd2, '0);
		add_row(ACT_PRESS, {1'b0, SC_SPACE}, 7'b0010000, 7'b0010000, 1'b0, 2'd2, '0);
		add_row(ACT_PRESS, {1'b1, SC_LEFT}, 7'b0010001, 7'b0010000, 1'b0, 2'd2, '0);
		add_row(ACT_PRESS, {1'b1, SC_UP}, 7'b0010001, 7'b0010100, 1'b0, 2'd2, '0);
		// Keypad 6 shares the right arrow code but has no E0 prefix
		add_row(ACT_PRESS, {1'b0, SC_RIGHT}, 7'b0010001, 7'b0010100, 1'b0, 2'd2, '0);
		add_row(ACT_PRESS, {1'b1, SC_RIGHT}, 7'b0010011, 7'b0010100, 1'b0, 2'd2, '0);
		add_row(ACT_PRESS, {1'b1, SC_DOWN}, 7'b0010011, 7'b0011100, 1'b0, 2'd2, '0);
		add_row(ACT_RELEASE, {1'b1, SC_RIGHT}, 7'b0010001, 7'b0011100, 1'b0, 2'd2, '0);
		add_row(ACT_RELEASE, {1'b1, SC_DOWN}, 7'b0010001, 7'b0010100, 1'b0, 2'd2, '0);
		add_row(ACT_BAD_PARITY, {1'b0, SC_5}, 7'b0010001, 7'b0010100, 1'b0, 2'd2, '0);
		add_row(ACT_RELEASE, {1'b1, SC_LEFT}, 7'b0010000, 7'b0010100, 1'b0, 2'd2, '0);
		add_row(ACT_RELEASE, {1'b0, SC_SPACE}, 7'b0000000, 7'b0000100, 1'b0, 2'd2, '0);
		repeat (3) add_row(ACT_JOY_RAND, {1'b1, 8'h01}, '0, '0, 1'b0, 2'd2, '0);
		add_row(ACT_JOY, 16'h0000, 7'b0000000, 7'b0000100, 1'b0, 2'd2, '0);
		add_row(ACT_CFG, {CMD_SET_STATUS, 16'h0008}, 7'b0000010, 7'b0000000, 1'b0, 2'd1, '0);
		repeat (3) add_row(ACT_JOY_RAND, {1'b0, 8'h01}, '0, '0, 1'b0, 2'd1, '0);
		add_row(ACT_JOY, 16'h0412, 7'b0010011, 7'b0010100, 1'b0, 2'd1, '0);
		add_row(ACT_JOY, 16'h0000, 7'b0000010, 7'b0000000, 1'b0, 2'd1, '0);
		add_row(ACT_RELEASE, {1'b1, SC_UP}, 7'b0000000, 7'b0000000, 1'b0, 2'd1, '0);
		// The joystick up bits only show once the up key is no longer held
		add_row(ACT_JOY, 16'h0008, 7'b0000010, 7'b0000000, 1'b0, 2'd1, '0);
		add_row(ACT_JOY, 16'h0800, 7'b0000010, 7'b0000000, 1'b0, 2'd1, '0);
		add_row(ACT_JOY, 16'h0000, 7'b0000000, 7'b0000000, 1'b0, 2'd1, '0);
		add_row(ACT_PULSE, {CMD_PULSE_RESET, 16'h0000}, '0, '0, 1'b0, 2'd1, '0);
		add_row(ACT_CFG, {CMD_SET_BUTTONS, 16'h0002}, '0, '0, 1'b1, 2'd1, '0);
		add_row(ACT_CFG, {CMD_SET_BUTTONS, 16'h0000}, '0, '0, 1'b0, 2'd1, '0);
		add_row(ACT_CFG, {CMD_NOP, 16'hFFFF}, '0, '0, 1'b0, 2'd1, '0);
		add_row(ACT_AUDIO, 16'h0000, '0, '0, 1'b0, 2'd1, 11'd0);
		add_row(ACT_AUDIO, 16'hFFFF, '0, '0, 1'b0, 2'd1, 11'd1275);
		add_row(ACT_AUDIO, 16'h4011, '0, '0, 1'b0, 2'd1, 11'd273);
		add_row(ACT_AUDIO, 16'h0080, '0, '0, 1'b0, 2'd1, 11'd128);
		repeat (3) add_row(ACT_AUDIO_RAND, '0, '0, '0, 1'b0, 2'd1, '0);
	endtask

	initial begin
		row_t        row;
		logic [31:0] rnd;
		joy_t        j0;
		joy_t        j1;
		int          waited;
		ps2_clk    = 1'b1;
		ps2_data   = 1'b1;
		cfg_req    = 1'b0;
		cfg_cmd    = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		audio_a    = '0;
		audio_b    = '0;
		timed_out  = 1'b0;
		seed       = 32'hbbf2_ae5d;
		build_table();

		waited = 0;
		@(posedge clk_sys);
		while (reset !== 1'b0 && waited < 20) begin
			@(posedge clk_sys);
			waited++;
		end
		if (reset !== 1'b0) begin
			$display("Timeout: reset was never released");
			timed_out = 1'b1;
		end

		for (int i = 0; i < rows.size() && !timed_out; i++) begin
			row = rows[i];
			chk.start_test();
			case (row.action)
				ACT_CFG:        send_cfg(row.operand);
				ACT_PULSE: begin
					fork
						chk.count_reset_pulse(RESET_PULSE_CYCLES);
						send_cfg(row.operand);
					join
				end
				ACT_PRESS:      send_key(row.operand[8:0], 1'b0, 1'b0);
				ACT_RELEASE:    send_key(row.operand[8:0], 1'b1, 1'b0);
				ACT_BAD_PARITY: send_key(row.operand[8:0], 1'b0, 1'b1);
				ACT_JOY, ACT_JOY_RAND: begin
					j0 = row.operand[7:0];
					j1 = row.operand[15:8];
					if (row.action == ACT_JOY_RAND) begin
						rnd = $random(seed);
						j0 = rnd[7:0];
						j1 = rnd[15:8];
						map_players(row.operand[7:0], j0, j1, row.operand[8],
							row.exp_p1, row.exp_p2);
					end
					@(posedge clk_sys);
					joystick_0 <= j0;
					joystick_1 <= j1;
				end
				ACT_AUDIO, ACT_AUDIO_RAND: begin
					if (row.action == ACT_AUDIO_RAND) begin
						rnd = $random(seed);
						row.operand[15:0] = rnd[15:0];
						row.exp_ones = row.operand[15:8] * 4 + row.operand[7:0];
					end
					@(posedge clk_sys);
					audio_a <= row.operand[7:0];
					audio_b <= row.operand[15:8];
				end
				default: ;
			endcase
			if (!timed_out) begin
				chk.check_outputs(row.exp_p1, row.exp_p2, row.exp_reset, row.exp_scan);
				if (row.action == ACT_AUDIO || row.action == ACT_AUDIO_RAND)
					chk.count_audio(row.exp_ones);
				chk.end_test(i, row.action.name());
			end
		end

		chk.report();
		if (timed_out || chk.error_count != 0)
			$display("Simulation FAILED");
		else
			$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
hw/arcade_pkg.sv
hw/ps2_keyboard_decoder.sv
hw/host_config_port.sv
hw/control_mapper.sv
hw/audio_dac.sv
hw/arcade_control_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_arcade_control.sv

/* Bender.yml */
package:
  name: arcade_control

sources:
  - files:
      - hw/arcade_pkg.sv
      - hw/ps2_keyboard_decoder.sv
      - hw/host_config_port.sv
      - hw/control_mapper.sv
      - hw/audio_dac.sv
      - hw/arcade_control_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_checker.sv
      - testbench/tb_arcade_control.sv
